/* verilog/fabric_params.svh */
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// memory space, counted in 16-bit words.
`define ADDR_W     19
`define ROM_WORDS  4096
`define RAM_WORDS  1024

// i/o word addresses, given as byte addresses with bit 0 clear.
`define IO_SCRATCH 16'hfffc
`define IO_ID      16'hfffa

// identification register contents.
`define ID_VALUE   16'h1d16

// boot rom words hold their index xor this.
`define ROM_SEED   16'h5a3c

`endif

/* verilog/bus_pkg.sv */
`include "fabric_params.svh"

package bus_pkg;

    // request from one master.
    // all fields stay stable from the rise of access until ack is sampled.
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;    // word address, byte address bits 19 to 1.
        logic [15:0]        wdata;
        logic               access;  // held high until ack.
        logic               wr_en;
        logic [1:0]         bytesel; // bit 0 low byte, bit 1 high byte.
        logic               io;      // i/o cycle, only set on the data bus.
    } bus_req_t;

    // response to one master.
    // rdata stays zero outside the ack cycle so that responses can be or-ed.
    typedef struct packed {
        logic [15:0] rdata;
        logic        ack;    // one cycle per transfer.
    } bus_rsp_t;

endpackage

/* verilog/mem_side.sv */
`timescale 1ns/1ns
`include "fabric_params.svh"

module mem_side (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t instr_req,
    input  bus_pkg::bus_req_t data_req,
    output bus_pkg::bus_rsp_t instr_rsp,
    output bus_pkg::bus_rsp_t data_rsp
);

    localparam int ROM_AW = $clog2(`ROM_WORDS);
    localparam int RAM_AW = $clog2(`RAM_WORDS);

    bus_pkg::bus_req_t data_mem_req;
    bus_pkg::bus_req_t shared_req;

    logic grant_valid;
    logic grant_data;
    logic last_data;
    logic sel_data;

    logic        rom_sel;
    logic        accept;
    logic        ram_we;
    logic        stor_ack;
    logic        rom_hit_q;
    logic [15:0] rom_q;
    logic [15:0] ram_q;
    logic [15:0] stor_rdata;

    logic [ROM_AW-1:0] rom_idx;
    logic [RAM_AW-1:0] ram_idx;

    logic [15:0] rom [0:`ROM_WORDS-1];
    logic [15:0] ram [0:`RAM_WORDS-1];

    ////////////////////
    // arbiter

    // i/o cycles belong to io_ports.
    always_comb begin
        data_mem_req = data_req;
        data_mem_req.access = data_req.access & ~data_req.io;
    end

    // while idle the choice is combinational and gets captured at the edge
    // that storage samples.
    always_comb begin
        if (grant_valid)
            sel_data = grant_data;
        else
            sel_data = data_mem_req.access && (!instr_req.access || !last_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_data  <= 1'b0;
            last_data   <= 1'b0; // data master wins the first contest.
        end else if (grant_valid && stor_ack) begin
            grant_valid <= 1'b0;
        end else if (!grant_valid && shared_req.access) begin
            grant_valid <= 1'b1;
            grant_data  <= sel_data;
            last_data   <= sel_data;
        end
    end

    assign shared_req = sel_data ? data_mem_req : instr_req;

    ////////////////////
    // decode and storage

    // top 8 KiB of the 1 MiB space is rom.
    assign rom_sel = &shared_req.addr[`ADDR_W-1:ROM_AW];
    assign rom_idx = shared_req.addr[ROM_AW-1:0];
    assign ram_idx = shared_req.addr[RAM_AW-1:0]; // mirrored over the rest.

    assign accept = shared_req.access && !stor_ack;
    assign ram_we = accept && shared_req.wr_en && !rom_sel;

    always_ff @(posedge clk) begin
        if (reset)
            stor_ack <= 1'b0;
        else
            stor_ack <= accept;
    end

    initial begin
        for (int i = 0; i < `ROM_WORDS; i++)
            rom[i] = i[15:0] ^ `ROM_SEED;
    end

    // rom writes are acked and dropped.
    always_ff @(posedge clk) begin
        rom_q     <= rom[rom_idx];
        rom_hit_q <= rom_sel;
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            if (shared_req.bytesel[0])
                ram[ram_idx][7:0] <= shared_req.wdata[7:0];
            if (shared_req.bytesel[1])
                ram[ram_idx][15:8] <= shared_req.wdata[15:8];
        end
        ram_q <= ram[ram_idx];
    end

    ////////////////////
    // response routing

    always_comb begin
        stor_rdata = 16'h0000;
        if (stor_ack)
            stor_rdata = rom_hit_q ? rom_q : ram_q;
    end

    // only the granted master sees the ack.
    always_comb begin
        instr_rsp = '0;
        data_rsp  = '0;
        if (stor_ack && grant_valid) begin
            if (grant_data) begin
                data_rsp.ack   = 1'b1;
                data_rsp.rdata = stor_rdata;
            end else begin
                instr_rsp.ack   = 1'b1;
                instr_rsp.rdata = stor_rdata;
            end
        end
    end

    ////////////////////
    // checks

    // the master picked at the sampling edge keeps the bus through its ack.
    property grant_held;
        @(posedge clk) disable iff (reset)
            (shared_req.access && !stor_ack) |=>
                (data_rsp.ack == $past(sel_data) && instr_rsp.ack == !$past(sel_data));
    endproperty

    property ack_single_cycle;
        @(posedge clk) disable iff (reset)
            (instr_rsp.ack || data_rsp.ack) |=> !(instr_rsp.ack || data_rsp.ack);
    endproperty

    a_grant_held: assert property (grant_held)
        else $error("mem_side: grant moved before ack.");

    a_ack_single_cycle: assert property (ack_single_cycle)
        else $error("mem_side: memory ack longer than one cycle.");

endmodule

/* verilog/io_ports.sv */
`timescale 1ns/1ns
`include "fabric_params.svh"

module io_ports (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t data_req,
    output bus_pkg::bus_rsp_t io_rsp
);

    logic        accept;
    logic        scratch_cs;
    logic        id_cs;
    logic        default_cs;
    logic        scratch_ack;
    logic        id_ack;
    logic        default_ack;
    logic [15:0] scratch;

    ////////////////////
    // port decode

    // the ack cycle blocks a second pick-up of a held access.
    assign accept = data_req.access && data_req.io && !io_rsp.ack;

    always_comb begin
        scratch_cs = 1'b0;
        id_cs      = 1'b0;
        default_cs = 1'b0;
        if (accept) begin
            case ({data_req.addr[14:0], 1'b0})
                `IO_SCRATCH: scratch_cs = 1'b1;
                `IO_ID:      id_cs      = 1'b1;
                default:     default_cs = 1'b1; // reads zero, drops writes.
            endcase
        end
    end

    ////////////////////
    // ports

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch_ack <= 1'b0;
            id_ack      <= 1'b0;
            default_ack <= 1'b0;
            scratch     <= 16'h0000;
        end else begin
            scratch_ack <= scratch_cs;
            id_ack      <= id_cs;
            default_ack <= default_cs;
            if (scratch_cs && data_req.wr_en) begin
                if (data_req.bytesel[0])
                    scratch[7:0] <= data_req.wdata[7:0];
                if (data_req.bytesel[1])
                    scratch[15:8] <= data_req.wdata[15:8];
            end
        end
    end

    // each port drives zero unless it is acking.
    always_comb begin
        io_rsp.ack   = scratch_ack | id_ack | default_ack;
        io_rsp.rdata = (scratch_ack ? scratch : 16'h0000) |
                       (id_ack ? `ID_VALUE : 16'h0000);
    end

    // every i/o ack answers an i/o access seen one edge earlier.
    property ack_follows_access;
        @(posedge clk) disable iff (reset)
            io_rsp.ack |-> $past(data_req.access && data_req.io);
    endproperty

    a_ack_follows_access: assert property (ack_follows_access)
        else $error("io_ports: ack without a prior i/o access.");

endmodule

/* verilog/data_return.sv */
`timescale 1ns/1ns

module data_return (
    input  bus_pkg::bus_req_t data_req,
    input  bus_pkg::bus_rsp_t mem_data_rsp,
    input  bus_pkg::bus_rsp_t io_rsp,
    output bus_pkg::bus_rsp_t data_rsp,
    input  logic              clk
);

    // both sides are zero when idle so an or is the whole mux.
    assign data_rsp = mem_data_rsp | io_rsp;

    ////////////////////
    // checks

    property acks_exclusive;
        @(posedge clk) mem_data_rsp.ack |-> !io_rsp.ack;
    endproperty

    // the request is still held in its ack cycle.
    property ack_source_matches;
        @(posedge clk)
            (mem_data_rsp.ack |-> !data_req.io) and (io_rsp.ack |-> data_req.io);
    endproperty

    a_acks_exclusive: assert property (acks_exclusive)
        else $error("data_return: memory and i/o ack together.");

    a_ack_source_matches: assert property (ack_source_matches)
        else $error("data_return: ack from the wrong side for this cycle type.");

endmodule

/* verilog/bus_fabric.sv */
`timescale 1ns/1ns

module bus_fabric (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t instr_req,
    input  bus_pkg::bus_req_t data_req,
    output bus_pkg::bus_rsp_t instr_rsp,
    output bus_pkg::bus_rsp_t data_rsp
);

    bus_pkg::bus_rsp_t mem_data_rsp;
    bus_pkg::bus_rsp_t io_rsp;

    // memory arbitration, decode and storage.
    mem_side u_mem_side (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .data_req  (data_req),
        .instr_rsp (instr_rsp),
        .data_rsp  (mem_data_rsp)
    );

    // i/o port decode.
    io_ports u_io_ports (
        .clk      (clk),
        .reset    (reset),
        .data_req (data_req),
        .io_rsp   (io_rsp)
    );

    data_return u_data_return (
        .data_req     (data_req),
        .mem_data_rsp (mem_data_rsp),
        .io_rsp       (io_rsp),
        .data_rsp     (data_rsp),
        .clk          (clk)
    );

endmodule

/* bench/bus_checker.sv */
`timescale 1ns/1ns

module bus_checker (
    input logic              clk,
    input logic              reset,
    input bus_pkg::bus_req_t instr_req,
    input bus_pkg::bus_req_t data_req,
    input bus_pkg::bus_rsp_t instr_rsp,
    input bus_pkg::bus_rsp_t data_rsp
);

    typedef struct packed {
        logic [15:0] value;
        logic        is_read; // write acks are only counted.
    } expect_t;

    expect_t instr_q[$];
    expect_t data_q[$];

    int   error_count  = 0;
    int   ack_count    = 0;
    int   test_count   = 0;
    int   test_acks    = 0;
    int   test_errors  = 0;
    int   cycle        = 0;
    int   io_start     = 0;
    logic io_seen      = 1'b0;
    int   instr_waited = 0;
    int   data_waited  = 0;

    task automatic post_instr(input logic [15:0] value);
        instr_q.push_back({value, 1'b1});
    endtask

    task automatic post_data(input logic [15:0] value, input logic is_read);
        data_q.push_back({value, is_read});
    endtask

    task automatic report_text(input string what);
        $display("%0t ns: %s.", $time, what);
        error_count++;
        test_errors++;
    endtask

    task automatic compare(input string name, input expect_t e, input logic [15:0] rdata);
        ack_count++;
        test_acks++;
        if (e.is_read && rdata !== e.value) begin
            $display("[FAIL] %s = %h, expected %h", name, rdata, e.value);
            error_count++;
            test_errors++;
        end
    endtask

    // rdata reads zero outside its ack cycle.
    task automatic check_idle(input string name, input bus_pkg::bus_rsp_t rsp);
        if (!rsp.ack && rsp.rdata !== 16'h0000) begin
            $display("[FAIL] %s = %h outside ack, expected %h", name, rsp.rdata, 16'h0000);
            error_count++;
            test_errors++;
        end
    endtask

    ////////////////////
    // i/o timing and fairness

    task automatic watch_io();
        if (data_rsp.ack && data_req.io) begin
            if (!io_seen || cycle != io_start + 1)
                report_text("i/o ack did not come one cycle after the access");
            io_seen = 1'b0;
        end else if (io_seen && cycle > io_start + 1) begin
            report_text("no i/o ack one cycle after the access");
            io_seen = 1'b0;
        end else if (!io_seen && data_req.access && data_req.io) begin
            io_seen  = 1'b1;
            io_start = cycle;
        end
    endtask

    // each waiting master may see at most one transfer of the other.
    task automatic watch_waits();
        if (instr_rsp.ack) begin
            instr_waited = 0;
        end else if (instr_req.access && data_rsp.ack && !data_req.io) begin
            instr_waited++;
            if (instr_waited > 1)
                report_text("instruction master waited for more than one data transfer");
        end
        if (data_rsp.ack && !data_req.io) begin
            data_waited = 0;
        end else if (data_req.access && !data_req.io && instr_rsp.ack) begin
            data_waited++;
            if (data_waited > 1)
                report_text("data master waited for more than one instruction transfer");
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (instr_rsp.ack) begin
                if (instr_q.size() == 0 || !instr_req.access)
                    report_text("ack on the instruction bus without a request");
                else
                    compare("instr_rsp.rdata", instr_q.pop_front(), instr_rsp.rdata);
            end
            if (data_rsp.ack) begin
                if (data_q.size() == 0 || !data_req.access)
                    report_text("ack on the data bus without a request");
                else
                    compare("data_rsp.rdata", data_q.pop_front(), data_rsp.rdata);
            end
            check_idle("instr_rsp.rdata", instr_rsp);
            check_idle("data_rsp.rdata", data_rsp);
            watch_io();
            watch_waits();
        end
        cycle++;
    end

    ////////////////////
    // reporting

    task automatic finish_test(input string name);
        test_count++;
        $display("%-10s %5d acks, %0d errors", name, test_acks, test_errors);
        test_acks   = 0;
        test_errors = 0;
    endtask

    task automatic report_totals();
        if (instr_q.size() != 0)
            report_text("instruction requests were left without an ack");
        if (data_q.size() != 0)
            report_text("data requests were left without an ack");
        $display("totals: %0d tests, %0d acks, %0d errors", test_count, ack_count, error_count);
    endtask

endmodule

/* bench/bus_fabric_tb.sv */
`timescale 1ns/1ns
`include "fabric_params.svh"

module bus_fabric_tb;

    localparam int ROM_AW       = $clog2(`ROM_WORDS);
    localparam int RAM_AW       = $clog2(`RAM_WORDS);
    localparam int RESET_CYCLES = 8;
    localparam int N_ROM        = 64;
    localparam int N_BYTE       = 200;
    localparam int N_READ       = 100;
    localparam int N_IO         = 60;
    localparam int N_CONT       = 150;
    localparam int N_ISO        = 16;

    // transfers of both masters added up, 8 cycles each at worst.
    localparam int XFERS = 3 * N_ROM + `RAM_WORDS + N_BYTE + 3 * N_READ + 2 * N_IO + 2
                           + 2 * N_CONT + 4 * N_ISO;
    localparam int WATCHDOG_NS = (XFERS * 8 + RESET_CYCLES + 50) * 10;

    logic              clk;
    logic              reset;
    bus_pkg::bus_req_t instr_req;
    bus_pkg::bus_req_t data_req;
    bus_pkg::bus_rsp_t instr_rsp;
    bus_pkg::bus_rsp_t data_rsp;

    logic [15:0] ram_model [0:`RAM_WORDS-1];
    logic [15:0] scratch_model;

    bus_fabric u_bus_fabric (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .data_req  (data_req),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_rsp)
    );

    bus_checker u_bus_checker (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .data_req  (data_req),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transfer never finished.", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // reference model

    function automatic logic is_rom(input logic [`ADDR_W-1:0] addr);
        return &addr[`ADDR_W-1:ROM_AW]; // top seven bits all ones.
    endfunction

    function automatic logic [15:0] io_port(input logic [`ADDR_W-1:0] addr);
        return {addr[14:0], 1'b0};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wdata,
                                                input logic [1:0] bytesel);
        logic [15:0] r;
        r = old;
        if (bytesel[0])
            r[7:0] = wdata[7:0];
        if (bytesel[1])
            r[15:8] = wdata[15:8];
        return r;
    endfunction

    function automatic logic [15:0] mem_expect(input logic [`ADDR_W-1:0] addr);
        if (is_rom(addr))
            return addr[ROM_AW-1:0] ^ `ROM_SEED;
        return ram_model[addr[RAM_AW-1:0]]; // mirrored by the low bits.
    endfunction

    function automatic logic [15:0] io_expect(input logic [`ADDR_W-1:0] addr);
        if (io_port(addr) == `IO_SCRATCH)
            return scratch_model;
        if (io_port(addr) == `IO_ID)
            return `ID_VALUE;
        return 16'h0000;
    endfunction

    ////////////////////
    // address picks

    function automatic logic [`ADDR_W-1:0] rom_addr();
        logic [`ADDR_W-1:0] a;
        a = `ADDR_W'($urandom);
        a[`ADDR_W-1:ROM_AW] = '1;
        return a;
    endfunction

    function automatic logic [`ADDR_W-1:0] ram_addr(input int idx);
        logic [`ADDR_W-1:0] a;
        a = `ADDR_W'($urandom);
        a[RAM_AW-1:0] = idx[RAM_AW-1:0];
        if (is_rom(a))
            a[`ADDR_W-1] = 1'b0;
        return a;
    endfunction

    function automatic logic [`ADDR_W-1:0] io_addr(input logic [15:0] port);
        logic [`ADDR_W-1:0] a;
        a = '0;
        a[14:0] = port[15:1];
        return a;
    endfunction

    function automatic logic [`ADDR_W-1:0] unclaimed_io_addr();
        logic [15:0] port;
        port = 16'($urandom) & 16'hfffe;
        if (port == `IO_SCRATCH || port == `IO_ID)
            port[4] = ~port[4];
        return io_addr(port);
    endfunction

    function automatic int idle_cycles();
        return $urandom_range(2);
    endfunction

    ////////////////////
    // masters

    task automatic instr_read(input logic [`ADDR_W-1:0] addr, input int gap);
        repeat (gap) @(negedge clk);
        instr_req.addr   = addr;
        instr_req.access = 1'b1;
        u_bus_checker.post_instr(mem_expect(addr));
        do @(posedge clk); while (!instr_rsp.ack);
        @(negedge clk);
        instr_req.access = 1'b0;
    endtask

    task automatic data_xfer(input logic [`ADDR_W-1:0] addr, input logic [15:0] wdata,
                             input logic wr_en, input logic [1:0] bytesel, input logic io,
                             input int gap);
        logic [15:0] expected;
        repeat (gap) @(negedge clk);
        // only this master writes, so the shadow can move at issue.
        if (io) begin
            expected = io_expect(addr);
            if (wr_en && io_port(addr) == `IO_SCRATCH)
                scratch_model = merge_bytes(scratch_model, wdata, bytesel);
        end else begin
            expected = mem_expect(addr);
            if (wr_en && !is_rom(addr))
                ram_model[addr[RAM_AW-1:0]] = merge_bytes(expected, wdata, bytesel);
        end
        data_req.addr    = addr;
        data_req.wdata   = wdata;
        data_req.wr_en   = wr_en;
        data_req.bytesel = bytesel;
        data_req.io      = io;
        data_req.access  = 1'b1;
        u_bus_checker.post_data(expected, !wr_en);
        do @(posedge clk); while (!data_rsp.ack);
        @(negedge clk);
        data_req.access = 1'b0;
    endtask

    ////////////////////
    // tests

    task automatic rom_test();
        fork
            for (int i = 0; i < N_ROM; i++)
                instr_read(rom_addr(), idle_cycles());
            begin
                logic [`ADDR_W-1:0] a;
                for (int i = 0; i < N_ROM; i++) begin
                    a = rom_addr();
                    if ($urandom_range(3) == 0)
                        data_xfer(a, 16'($urandom), 1'b1, 2'b11, 1'b0, idle_cycles());
                    data_xfer(a, 16'h0000, 1'b0, 2'b11, 1'b0, idle_cycles());
                end
            end
        join
    endtask

    task automatic ram_test();
        for (int i = 0; i < `RAM_WORDS; i++)
            data_xfer(ram_addr(i), 16'($urandom), 1'b1, 2'b11, 1'b0, 0);
        u_bus_checker.finish_test("ram_fill");
        for (int i = 0; i < N_BYTE; i++)
            data_xfer(ram_addr($urandom_range(`RAM_WORDS - 1)), 16'($urandom), 1'b1,
                      2'($urandom), 1'b0, idle_cycles());
        fork
            for (int i = 0; i < N_READ; i++)
                instr_read(ram_addr($urandom_range(`RAM_WORDS - 1)), idle_cycles());
            for (int i = 0; i < N_READ; i++)
                data_xfer(ram_addr($urandom_range(`RAM_WORDS - 1)), 16'h0000, 1'b0, 2'b11,
                          1'b0, idle_cycles());
        join
    endtask

    task automatic io_test();
        fork
            for (int i = 0; i < N_READ; i++)
                instr_read(ram_addr($urandom_range(`RAM_WORDS - 1)), idle_cycles());
            begin
                logic [`ADDR_W-1:0] a;
                data_xfer(io_addr(`IO_SCRATCH), 16'h0000, 1'b0, 2'b11, 1'b1, 0);
                data_xfer(io_addr(`IO_ID), 16'h0000, 1'b0, 2'b11, 1'b1, 0);
                for (int i = 0; i < N_IO; i++) begin
                    case ($urandom_range(3))
                        0: a = io_addr(`IO_SCRATCH);
                        1: a = io_addr(`IO_ID); // writes here must not stick.
                        default: a = unclaimed_io_addr();
                    endcase
                    if ($urandom_range(1))
                        data_xfer(a, 16'($urandom), 1'b1, 2'($urandom), 1'b1, idle_cycles());
                    data_xfer(a, 16'h0000, 1'b0, 2'b11, 1'b1, idle_cycles());
                end
            end
        join
    endtask

    // back to back on both buses. data writes stay in the upper ram half
    // so the instruction reads below never race them.
    task automatic contention_test();
        fork
            for (int i = 0; i < N_CONT; i++) begin
                if ($urandom_range(1))
                    instr_read(rom_addr(), 0);
                else
                    instr_read(ram_addr($urandom_range(`RAM_WORDS / 2 - 1)), 0);
            end
            begin
                int idx;
                for (int i = 0; i < N_CONT; i++) begin
                    idx = $urandom_range(`RAM_WORDS - 1);
                    if ($urandom_range(1))
                        data_xfer(ram_addr(idx | (`RAM_WORDS / 2)), 16'($urandom), 1'b1,
                                  2'($urandom), 1'b0, 0);
                    else
                        data_xfer(ram_addr(idx), 16'h0000, 1'b0, 2'b11, 1'b0, 0);
                end
            end
        join
    endtask

    task automatic isolation_test();
        logic [`ADDR_W-1:0] a;
        for (int i = 0; i < N_ISO; i++) begin
            a = ram_addr($urandom_range(`RAM_WORDS - 1));
            data_xfer(a, 16'($urandom), 1'b1, 2'b11, 1'b1, idle_cycles());
            data_xfer(a, 16'h0000, 1'b0, 2'b11, 1'b0, idle_cycles());
            a = io_addr(`IO_SCRATCH);
            data_xfer(a, 16'($urandom), 1'b1, 2'b11, 1'b0, idle_cycles());
            data_xfer(a, 16'h0000, 1'b0, 2'b11, 1'b1, idle_cycles());
        end
    endtask

    initial begin
        int unsigned seed;
        seed = 32'h9263_eb1f;
        void'($urandom(seed));
        instr_req         = '0;
        instr_req.bytesel = 2'b11;
        data_req          = '0;
        scratch_model     = 16'h0000;
        reset             = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        rom_test();
        u_bus_checker.finish_test("rom_reads");
        ram_test();
        u_bus_checker.finish_test("ram_bytes");
        io_test();
        u_bus_checker.finish_test("io_ports");
        contention_test();
        u_bus_checker.finish_test("contention");
        isolation_test();
        u_bus_checker.finish_test("isolation");

        u_bus_checker.report_totals();
        if (u_bus_checker.error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/bus_pkg.sv
verilog/mem_side.sv
verilog/io_ports.sv
verilog/data_return.sv
verilog/bus_fabric.sv
bench/bus_checker.sv
bench/bus_fabric_tb.sv

/* Bender.yml */
package:
  name: bus_fabric

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bus_pkg.sv
      - verilog/mem_side.sv
      - verilog/io_ports.sv
      - verilog/data_return.sv
      - verilog/bus_fabric.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/bus_checker.sv
      - bench/bus_fabric_tb.sv
